/* design/axi4_lite_pkg.sv */
// AXI4-Lite read channel definitions
// Only AR and R exist here since the fetch path never writes
`default_nettype none

package axi4_lite_pkg;

  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;

  localparam logic [2:0] ARPROT_INSN = 3'b100;             // Unprivileged, secure, instruction

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef struct packed {
    logic       arvalid;
    axi_addr_t  araddr;
    logic [2:0] arprot;
  } axi_ar_req_t;

  typedef struct packed {
    logic arready;
  } axi_ar_rsp_t;

  typedef struct packed {
    logic rready;
  } axi_r_req_t;

  typedef struct packed {
    logic      rvalid;
    axi_data_t rdata;
    axi_resp_e rresp;
  } axi_r_rsp_t;

endpackage

`default_nettype wire

/* design/branch_target_buffer.sv */
// Direct-mapped branch target buffer
// Lookup is combinational on the fetch pc, training comes from execute.
// A taken update installs the entry, a not-taken one evicts it on a tag match
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
  input  logic                      CLK,
  input  logic                      nRST,
  input  rv_fetch_pkg::word_t       lookup_pc,
  input  rv_fetch_pkg::btb_update_t update,
  output logic                      predict_taken,
  output rv_fetch_pkg::word_t       target
);

  localparam int IDX_LO = 2;                               // Word aligned, byte bits ignored
  localparam int IDX_HI = IDX_LO + rv_fetch_pkg::BTB_INDEX_W - 1;

  logic [rv_fetch_pkg::BTB_ENTRIES-1:0] valid;
  rv_fetch_pkg::btb_tag_t               tag_mem    [rv_fetch_pkg::BTB_ENTRIES];
  rv_fetch_pkg::word_t                  target_mem [rv_fetch_pkg::BTB_ENTRIES];

  rv_fetch_pkg::btb_index_t lu_idx;
  rv_fetch_pkg::btb_tag_t   lu_tag;
  rv_fetch_pkg::btb_index_t up_idx;
  rv_fetch_pkg::btb_tag_t   up_tag;

  assign lu_idx = lookup_pc[IDX_HI:IDX_LO];
  assign lu_tag = lookup_pc[31:IDX_HI+1];
  assign up_idx = update.pc[IDX_HI:IDX_LO];
  assign up_tag = update.pc[31:IDX_HI+1];

  assign predict_taken = valid[lu_idx] && (tag_mem[lu_idx] == lu_tag);
  assign target        = target_mem[lu_idx];               // Only meaningful on a hit

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;                                         // Cold BTB predicts nothing
    end else if (update.valid) begin
      if (update.taken) begin
        valid[up_idx] <= 1'b1;
      end else if (tag_mem[up_idx] == up_tag) begin
        valid[up_idx] <= 1'b0;                             // Leave another branch's entry alone
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (update.valid && update.taken) begin
      tag_mem[up_idx]    <= up_tag;
      target_mem[up_idx] <= update.target;
    end
  end

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
// Fetch stage datapath
// Keeps the program counter, picks the next PC, swaps returned words
// into instruction order, loads the fetch/execute register and reports
// misaligned and access faults to the hazard logic
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                       CLK,
  input  logic                       nRST,
  input  rv_fetch_pkg::redirect_t    priv_redirect,
  input  rv_fetch_pkg::redirect_t    br_redirect,
  input  logic                       predict_taken,
  input  rv_fetch_pkg::word_t        predict_target,
  input  logic                       rsp_done,
  input  logic                       rsp_err,
  input  logic                       timeout,
  input  rv_fetch_pkg::word_t        rsp_data,
  input  logic                       if_ex_stall,
  input  logic                       if_ex_flush,
  output rv_fetch_pkg::word_t        pc,
  output logic                       pc_aligned,
  output logic                       halted,
  output logic                       redirect_any,
  output rv_fetch_pkg::fetch_ex_t    fetch_ex,
  output rv_fetch_pkg::fetch_fault_t fault
);

  rv_fetch_pkg::word_t       pc4;
  rv_fetch_pkg::word_t       npc;
  rv_fetch_pkg::word_t       instr;
  rv_fetch_pkg::fault_kind_e fault_kind;
  logic                      good_beat;
  logic                      mis_fault;
  logic                      acc_fault;

  assign pc4          = pc + 32'd4;
  assign pc_aligned   = (pc[1:0] == 2'b00);
  assign redirect_any = priv_redirect.valid | br_redirect.valid;
  assign good_beat    = rsp_done & ~rsp_err;               // Beat that carries an instruction

  // Memory returns little-endian bytes, execute expects them reversed
  assign instr = {rsp_data[7:0], rsp_data[15:8], rsp_data[23:16], rsp_data[31:24]};

  always_comb begin
    if (priv_redirect.valid) begin
      npc = priv_redirect.target;                          // Trap entry or return wins over all
    end else if (br_redirect.valid) begin
      npc = br_redirect.target;                            // Execute resolved a mispredict
    end else if (predict_taken) begin
      npc = predict_target;
    end else begin
      npc = pc4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= rv_fetch_pkg::RESET_PC;
    end else if (redirect_any || good_beat) begin
      pc <= npc;                                           // Otherwise hold until the word lands
    end
  end

  // A misaligned pc is reported once, then halted blocks a repeat
  assign mis_fault = ~pc_aligned & ~halted & ~redirect_any;
  assign acc_fault = (rsp_done & rsp_err) | timeout;       // Bus FSM never pairs these with a redirect

  always_comb begin
    if (mis_fault) begin
      fault_kind = rv_fetch_pkg::FAULT_MISALIGNED;
    end else if (acc_fault) begin
      fault_kind = rv_fetch_pkg::FAULT_ACCESS;
    end else begin
      fault_kind = rv_fetch_pkg::FAULT_NONE;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halted <= 1'b0;
    end else if (redirect_any) begin
      halted <= 1'b0;                                      // Only a redirect restarts fetch
    end else if (mis_fault || acc_fault) begin
      halted <= 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fault <= '0;
    end else begin
      fault.valid   <= mis_fault | acc_fault;              // Single-cycle pulse to hazard unit
      fault.kind    <= fault_kind;
      fault.epc     <= pc;
      fault.badaddr <= pc;                                 // pc still equals the issued araddr
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fetch_ex <= '0;
    end else if (if_ex_flush) begin
      fetch_ex <= '0;                                      // Flush beats a simultaneous load
    end else if (good_beat) begin
      fetch_ex.token      <= 1'b1;
      fetch_ex.pc         <= pc;
      fetch_ex.pc4        <= pc4;
      fetch_ex.instr      <= instr;
      fetch_ex.prediction <= predict_taken;
    end else if (!if_ex_stall) begin
      fetch_ex <= '0;                                      // Execute consumed it, insert a bubble
    end
  end

endmodule

`default_nettype wire

/* design/fetch_top.sv */
// Instruction fetch subsystem top level
// Joins the fetch datapath, AXI4-Lite read master, timeout timer and
// branch target buffer behind the bus and execute-side ports
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                       CLK,
  input  logic                       nRST,
  output axi4_lite_pkg::axi_ar_req_t ar_req,
  input  axi4_lite_pkg::axi_ar_rsp_t ar_rsp,
  output axi4_lite_pkg::axi_r_req_t  r_req,
  input  axi4_lite_pkg::axi_r_rsp_t  r_rsp,
  input  rv_fetch_pkg::redirect_t    priv_redirect,
  input  rv_fetch_pkg::redirect_t    br_redirect,
  input  rv_fetch_pkg::btb_update_t  btb_update,
  input  logic                       if_ex_stall,
  input  logic                       if_ex_flush,
  output rv_fetch_pkg::fetch_ex_t    fetch_ex,
  output rv_fetch_pkg::fetch_fault_t fault
);

  rv_fetch_pkg::word_t pc;
  rv_fetch_pkg::word_t predict_target;
  rv_fetch_pkg::word_t rsp_data;
  logic                pc_aligned;
  logic                halted;
  logic                redirect_any;
  logic                predict_taken;
  logic                rsp_done;
  logic                rsp_err;
  logic                timeout;
  logic                timer_run;
  logic                expired;

  fetch_stage fetch_stage_i (
    .CLK            (CLK),
    .nRST           (nRST),
    .priv_redirect  (priv_redirect),
    .br_redirect    (br_redirect),
    .predict_taken  (predict_taken),
    .predict_target (predict_target),
    .rsp_done       (rsp_done),
    .rsp_err        (rsp_err),
    .timeout        (timeout),
    .rsp_data       (rsp_data),
    .if_ex_stall    (if_ex_stall),
    .if_ex_flush    (if_ex_flush),
    .pc             (pc),
    .pc_aligned     (pc_aligned),
    .halted         (halted),
    .redirect_any   (redirect_any),
    .fetch_ex       (fetch_ex),
    .fault          (fault)
  );

  ifetch_bus_fsm bus_fsm_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .pc           (pc),
    .pc_aligned   (pc_aligned),
    .halted       (halted),
    .if_ex_stall  (if_ex_stall),
    .redirect_any (redirect_any),
    .expired      (expired),
    .ar_rsp       (ar_rsp),
    .r_rsp        (r_rsp),
    .ar_req       (ar_req),
    .r_req        (r_req),
    .rsp_done     (rsp_done),
    .rsp_err      (rsp_err),
    .timeout      (timeout),
    .timer_run    (timer_run),
    .rsp_data     (rsp_data)
  );

  ifetch_timeout_timer timer_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .run     (timer_run),
    .expired (expired)
  );

  branch_target_buffer btb_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .lookup_pc     (pc),
    .update        (btb_update),
    .predict_taken (predict_taken),
    .target        (predict_target)
  );

endmodule

`default_nettype wire

/* design/ifetch_bus_fsm.sv */
// Fetch bus master for an AXI4-Lite read port
// Issues one read per PC, holds AR until accepted, back-pressures R
// while execute stalls and throws away reads made stale by a redirect
`timescale 1ns/1ps
`default_nettype none

module ifetch_bus_fsm (
  input  logic                       CLK,
  input  logic                       nRST,
  input  rv_fetch_pkg::word_t        pc,
  input  logic                       pc_aligned,
  input  logic                       halted,
  input  logic                       if_ex_stall,
  input  logic                       redirect_any,
  input  logic                       expired,
  input  axi4_lite_pkg::axi_ar_rsp_t ar_rsp,
  input  axi4_lite_pkg::axi_r_rsp_t  r_rsp,
  output axi4_lite_pkg::axi_ar_req_t ar_req,
  output axi4_lite_pkg::axi_r_req_t  r_req,
  output logic                       rsp_done,
  output logic                       rsp_err,
  output logic                       timeout,
  output logic                       timer_run,
  output rv_fetch_pkg::word_t        rsp_data
);

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    DATA,
    DRAIN,
    WAIT_REDIRECT
  } state_e;

  state_e                   state;
  state_e                   next_state;
  axi4_lite_pkg::axi_addr_t araddr_q;
  logic                     stale;
  logic                     discard;
  logic                     r_fire;

  assign discard = stale | redirect_any;                   // Beat belongs to an abandoned pc
  assign r_fire  = r_rsp.rvalid & r_req.rready;

  assign ar_req.arvalid = (state == ADDR);
  assign ar_req.araddr  = araddr_q;
  assign ar_req.arprot  = axi4_lite_pkg::ARPROT_INSN;

  // Stale beats are taken at once, live ones wait for execute to free up
  assign r_req.rready = ((state == DATA) && (discard || !if_ex_stall)) || (state == DRAIN);

  assign rsp_done  = (state == DATA) && r_fire && !discard;
  assign rsp_err   = rsp_done && (r_rsp.rresp != axi4_lite_pkg::RESP_OKAY);
  assign rsp_data  = r_rsp.rdata;
  assign timeout   = (state == DATA) && !r_fire && expired && !discard;
  assign timer_run = (state == DATA) || (state == DRAIN);  // Drops in between, so the count restarts

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (pc_aligned && !halted && !redirect_any) begin
          next_state = ADDR;                               // pc is settled, start a read
        end
      end
      ADDR: begin
        if (ar_rsp.arready) begin
          next_state = DATA;
        end
      end
      DATA: begin
        if (r_fire) begin
          next_state = IDLE;
        end else if (expired) begin
          // A live read faults, a stale one is simply abandoned
          next_state = discard ? IDLE : WAIT_REDIRECT;
        end
      end
      WAIT_REDIRECT: begin
        if (redirect_any) begin
          next_state = DRAIN;                              // Late beat may still be on its way
        end
      end
      DRAIN: begin
        if (r_fire || expired) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      stale <= 1'b0;
    end else if (state == IDLE) begin
      stale <= 1'b0;                                       // New read starts clean
    end else if ((state == ADDR || state == DATA) && redirect_any) begin
      stale <= 1'b1;                                       // AR cannot be withdrawn, so mark it
    end
  end

  always_ff @(posedge CLK) begin
    if (state == IDLE && next_state == ADDR) begin
      araddr_q <= pc;                                      // Held stable until arready
    end
  end

endmodule

`default_nettype wire

/* design/ifetch_timeout_timer.sv */
// Read timeout counter
// Counts cycles while a read waits for its R beat and flags expiry
// when the wait reaches the limit
`timescale 1ns/1ps
`default_nettype none

module ifetch_timeout_timer (
  input  logic CLK,
  input  logic nRST,
  input  logic run,
  output logic expired
);

  rv_fetch_pkg::timeout_count_t count;

  assign expired = (count ==
    rv_fetch_pkg::timeout_count_t'(rv_fetch_pkg::TIMEOUT_CYCLES));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (!run) begin
      count <= '0;                                         // Idle cycles restart the wait
    end else if (!expired) begin
      count <= count + 1'b1;                               // Saturates at the limit
    end
  end

endmodule

`default_nettype wire

/* design/rv_fetch_pkg.sv */
// Instruction fetch types and constants for the two-stage RV32I pipeline
// Holds the word type, reset PC, branch target buffer geometry, read
// timeout limit and the structs passed between fetch and execute
`default_nettype none

package rv_fetch_pkg;

  typedef logic [31:0] word_t;                             // Instruction or address word

  localparam word_t RESET_PC = 32'h200;                    // First fetch address after reset

  localparam int BTB_ENTRIES = 16;                         // Direct-mapped, one branch per set
  localparam int BTB_INDEX_W = $clog2(BTB_ENTRIES);        // Index taken from pc[5:2]
  localparam int BTB_TAG_W   = 32 - BTB_INDEX_W - 2;       // Tag is everything above the index

  typedef logic [BTB_INDEX_W-1:0] btb_index_t;
  typedef logic [BTB_TAG_W-1:0]   btb_tag_t;

  localparam int TIMEOUT_CYCLES = 16;                      // R wait cycles before an access fault

  typedef logic [4:0] timeout_count_t;                     // Must reach TIMEOUT_CYCLES

  typedef struct packed {
    logic  token;                                          // Register holds a live instruction
    word_t pc;
    word_t pc4;
    word_t instr;                                          // Already in instruction byte order
    logic  prediction;                                     // BTB predicted this one taken
  } fetch_ex_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

  typedef struct packed {
    logic  valid;
    word_t pc;                                             // Address of the resolved branch
    word_t target;
    logic  taken;
  } btb_update_t;

  typedef enum logic [1:0] {
    FAULT_NONE       = 2'd0,
    FAULT_MISALIGNED = 2'd1,
    FAULT_ACCESS     = 2'd2
  } fault_kind_e;

  typedef struct packed {
    logic        valid;
    fault_kind_e kind;
    word_t       epc;
    word_t       badaddr;
  } fetch_fault_t;

endpackage

`default_nettype wire

/* fetch_top.f */
design/rv_fetch_pkg.sv
design/axi4_lite_pkg.sv
design/fetch_stage.sv
design/ifetch_bus_fsm.sv
design/ifetch_timeout_timer.sv
design/branch_target_buffer.sv
design/fetch_top.sv
sim/fetch_checker.sv
sim/fetch_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the fetch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_top_tb \
  -f fetch_top.f -o fetch_top_sim

output="$(./obj_dir/fetch_top_sim)"
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi

/* sim/fetch_checker.sv */
// Fetch bus and register assertions
// Bound to the fetch top level, checks the AR handshake, the reset
// release, token loading and the fault pulse width
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
  input logic                       CLK,
  input logic                       nRST,
  input axi4_lite_pkg::axi_ar_req_t ar_req,
  input axi4_lite_pkg::axi_ar_rsp_t ar_rsp,
  input axi4_lite_pkg::axi_r_req_t  r_req,
  input axi4_lite_pkg::axi_r_rsp_t  r_rsp,
  input rv_fetch_pkg::fetch_ex_t    fetch_ex,
  input rv_fetch_pkg::fetch_fault_t fault
);

  ar_hold_a: assert property (@(posedge CLK) disable iff (!nRST)
    (ar_req.arvalid && !ar_rsp.arready) |=> (ar_req.arvalid && $stable(ar_req.araddr)))
    else $error("AR request changed before arready");

  reset_quiet_a: assert property (@(posedge CLK) $rose(nRST) |-> !ar_req.arvalid)
    else $error("arvalid high in the cycle after reset release");

  token_load_a: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(fetch_ex.token) |-> $past(r_rsp.rvalid && r_req.rready))
    else $error("fetch_ex token rose without an R handshake");

  fault_pulse_a: assert property (@(posedge CLK) disable iff (!nRST)
    fault.valid |=> !fault.valid)
    else $error("fault valid lasted more than one cycle");

endmodule

bind fetch_top fetch_checker checker_i (
  .CLK      (CLK),
  .nRST     (nRST),
  .ar_req   (ar_req),
  .ar_rsp   (ar_rsp),
  .r_req    (r_req),
  .r_rsp    (r_rsp),
  .fetch_ex (fetch_ex),
  .fault    (fault)
);

`default_nettype wire

/* sim/fetch_top_tb.sv */
// Testbench for the instruction fetch subsystem
// Models an AXI4-Lite memory with random delays, drives redirects,
// stalls and BTB training, and checks every fetched token
`timescale 1ns/1ps
`default_nettype none

module fetch_top_tb;

  localparam logic [31:0] SEED      = 32'h5ec4_40eb;
  localparam logic [31:0] ERR_ADDR  = 32'h3C0;             // Answers SLVERR
  localparam logic [31:0] HANG_ADDR = 32'h3E0;             // Never answers
  localparam int          WAIT_MAX  = 1000;

  logic                       CLK;
  logic                       nRST;
  axi4_lite_pkg::axi_ar_req_t ar_req;
  axi4_lite_pkg::axi_ar_rsp_t ar_rsp;
  axi4_lite_pkg::axi_r_req_t  r_req;
  axi4_lite_pkg::axi_r_rsp_t  r_rsp;
  rv_fetch_pkg::redirect_t    priv_redirect;
  rv_fetch_pkg::redirect_t    br_redirect;
  rv_fetch_pkg::btb_update_t  btb_update;
  logic                       if_ex_stall;
  logic                       if_ex_flush;
  rv_fetch_pkg::fetch_ex_t    fetch_ex;
  rv_fetch_pkg::fetch_fault_t fault;

  logic [31:0]  mem [256];
  logic         btb_valid [16];
  logic [25:0]  btb_tag [16];
  logic [31:0]  btb_target [16];
  logic [31:0]  exp_q [$];
  logic [31:0]  mem_seed;
  logic [31:0]  stall_seed;
  logic         rand_on;
  logic         hold_stall;
  rv_fetch_pkg::fetch_ex_t prev_fe;
  logic         prev_hold;
  int           value_errs;
  int           other_errs;
  int           fault_count;

  fetch_top dut_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .ar_req        (ar_req),
    .ar_rsp        (ar_rsp),
    .r_req         (r_req),
    .r_rsp         (r_rsp),
    .priv_redirect (priv_redirect),
    .br_redirect   (br_redirect),
    .btb_update    (btb_update),
    .if_ex_stall   (if_ex_stall),
    .if_ex_flush   (if_ex_flush),
    .fetch_ex      (fetch_ex),
    .fault         (fault)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;                                 // 4 ns period
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Byte 0 of the memory word becomes the top byte of the instruction
  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = w[8*(3-i) +: 8];
    end
    return r;
  endfunction

  function automatic logic btb_hit(input logic [31:0] p);
    return btb_valid[p[5:2]] && (btb_tag[p[5:2]] == p[31:6]);
  endfunction

  function automatic logic [31:0] next_pc(input logic [31:0] p);
    return btb_hit(p) ? btb_target[p[5:2]] : p + 32'd4;
  endfunction

  function automatic rv_fetch_pkg::fetch_ex_t expected_fetch(input logic [31:0] p);
    rv_fetch_pkg::fetch_ex_t e;
    e.token      = 1'b1;
    e.pc         = p;
    e.pc4        = p + 32'd4;
    e.instr      = swap_bytes(mem[p[9:2]]);
    e.prediction = btb_hit(p);
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      value_errs++;
    end
  endtask

  // Memory model, one read at a time with 1 to 4 cycle AR and R delays
  initial begin
    logic [31:0] addr;
    int          n;
    ar_rsp   <= '0;
    r_rsp    <= '0;
    mem_seed  = SEED;
    forever begin
      n = 0;
      @(posedge CLK);
      while (!ar_req.arvalid && n < WAIT_MAX) begin
        @(posedge CLK);
        n++;
      end
      if (n >= WAIT_MAX) begin
        $display("Memory model saw no read request for %0d cycles", WAIT_MAX);
        other_errs++;
      end else begin
        mem_seed = lcg_next(mem_seed);
        repeat (mem_seed[17:16]) @(posedge CLK);
        ar_rsp.arready <= 1'b1;
        @(posedge CLK);                                    // arvalid is held, handshake here
        ar_rsp.arready <= 1'b0;
        addr = ar_req.araddr;
        check_value("ar_req.arprot", 32'h4, 32'(ar_req.arprot));  // Instruction access
        if (addr != HANG_ADDR) begin
          mem_seed = lcg_next(mem_seed);
          repeat (mem_seed[17:16]) @(posedge CLK);
          r_rsp.rvalid <= 1'b1;
          r_rsp.rdata  <= mem[addr[9:2]];
          r_rsp.rresp  <= (addr == ERR_ADDR) ? axi4_lite_pkg::RESP_SLVERR
                                             : axi4_lite_pkg::RESP_OKAY;
          n = 0;
          @(posedge CLK);
          while (!r_req.rready && n < WAIT_MAX) begin
            @(posedge CLK);
            n++;
          end
          if (n >= WAIT_MAX) begin
            $display("R beat for %h was never accepted", addr);
            other_errs++;
          end
          r_rsp <= '0;
        end
      end
    end
  end

  // Stall driver, random when enabled, otherwise follows hold_stall
  initial begin
    if_ex_stall <= 1'b0;
    stall_seed   = ~SEED;
    forever begin
      @(posedge CLK);
      stall_seed = lcg_next(stall_seed);
      if_ex_stall <= rand_on ? (stall_seed[17:16] == 2'd0) : hold_stall;
    end
  end

  // Comparing process, sampled mid-cycle when fetch_ex is settled
  always @(negedge CLK) begin
    rv_fetch_pkg::fetch_ex_t e;
    if (nRST) begin
      if (fault.valid) fault_count++;
      if (prev_hold && prev_fe.token && fetch_ex != prev_fe) begin
        $display("FAIL t=%0t fetch_ex expected=%h actual=%h", $time, prev_fe, fetch_ex);
        value_errs++;
      end else if (fetch_ex.token && (!prev_fe.token || fetch_ex != prev_fe)) begin
        if (exp_q.size() == 0) begin
          $display("Token for pc %h arrived with no expected pc", fetch_ex.pc);
          other_errs++;
        end else begin
          e = expected_fetch(exp_q.pop_front());
          check_value("fetch_ex.pc", e.pc, fetch_ex.pc);
          check_value("fetch_ex.pc4", e.pc4, fetch_ex.pc4);
          check_value("fetch_ex.instr", e.instr, fetch_ex.instr);
          check_value("fetch_ex.prediction", 32'(e.prediction), 32'(fetch_ex.prediction));
          exp_q.push_back(next_pc(e.pc));
        end
      end
    end
    prev_fe   = fetch_ex;
    prev_hold = if_ex_stall && !if_ex_flush;               // Applies at the coming edge
  end

  task automatic wait_token(input logic [31:0] p);
    int n;
    n = 0;
    @(negedge CLK);
    while (!(fetch_ex.token && fetch_ex.pc == p) && n < WAIT_MAX) begin
      @(negedge CLK);
      n++;
    end
    if (n >= WAIT_MAX) begin
      $display("Timed out waiting for a token with pc %h", p);
      other_errs++;
    end
  endtask

  // Returns in the cycle whose closing edge accepts an R beat
  task automatic wait_r_beat();
    int n;
    n = 0;
    @(negedge CLK);
    while (!(r_rsp.rvalid && r_req.rready) && n < WAIT_MAX) begin
      @(negedge CLK);
      n++;
    end
    if (n >= WAIT_MAX) begin
      $display("Timed out waiting for an R handshake");
      other_errs++;
    end
  endtask

  task automatic wait_fault(input rv_fetch_pkg::fault_kind_e kind, input logic [31:0] a);
    int n;
    n = 0;
    @(negedge CLK);
    while (!fault.valid && n < 100) begin
      @(negedge CLK);
      n++;
    end
    if (n >= 100) begin
      $display("Timed out waiting for a fault at %h", a);
      other_errs++;
    end else begin
      check_value("fault.kind", 32'(kind), 32'(fault.kind));
      check_value("fault.epc", a, fault.epc);
      check_value("fault.badaddr", a, fault.badaddr);
    end
  endtask

  // A request still held from before the fault may finish, a new one must not start
  task automatic check_no_new_read(input int cycles);
    logic was_valid;
    was_valid = ar_req.arvalid;
    repeat (cycles) begin
      @(negedge CLK);
      if (ar_req.arvalid && !was_valid) begin
        $display("Read request issued after a misaligned fault");
        other_errs++;
      end
      was_valid = ar_req.arvalid;
    end
  endtask

  task automatic send_redirect(input logic use_priv, input logic [31:0] priv_t,
                               input logic use_br, input logic [31:0] br_t,
                               input logic flush);
    @(posedge CLK);
    priv_redirect <= {use_priv, priv_t};
    br_redirect   <= {use_br, br_t};
    if_ex_flush   <= flush;
    @(posedge CLK);
    priv_redirect <= '0;
    br_redirect   <= '0;
    if_ex_flush   <= 1'b0;
    exp_q.delete();                                        // Privileged target wins
    exp_q.push_back(use_priv ? priv_t : br_t);
    if (flush) begin
      @(negedge CLK);
      if (fetch_ex != '0) begin
        $display("FAIL t=%0t fetch_ex expected=0 actual=%h", $time, fetch_ex);
        value_errs++;
      end
    end
  endtask

  // Execute stalls while the BTB is trained so no token is in doubt
  task automatic train_btb(input logic [31:0] p, input logic [31:0] t, input logic taken);
    hold_stall = 1'b1;
    repeat (3) @(posedge CLK);
    btb_update <= {1'b1, p, t, taken};
    if (taken) begin
      btb_valid[p[5:2]]  = 1'b1;
      btb_tag[p[5:2]]    = p[31:6];
      btb_target[p[5:2]] = t;
    end else if (btb_tag[p[5:2]] == p[31:6]) begin
      btb_valid[p[5:2]] = 1'b0;
    end
    @(posedge CLK);
    btb_update <= '0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    hold_stall = 1'b0;
  endtask

  task automatic finish_run();
    $display("Errors: value=%0d other=%0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  initial begin
    nRST          <= 1'b0;
    priv_redirect <= '0;
    br_redirect   <= '0;
    btb_update    <= '0;
    if_ex_flush   <= 1'b0;
    rand_on     = 1'b0;
    hold_stall  = 1'b0;
    value_errs  = 0;
    other_errs  = 0;
    fault_count = 0;
    prev_fe     = '0;
    prev_hold   = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h9E37_79B1) ^ {16'(i * 4), ~16'(i * 4)};
    end
    for (int i = 0; i < 16; i++) begin
      btb_valid[i]  = 1'b0;
      btb_tag[i]    = '0;
      btb_target[i] = '0;
    end
    exp_q.push_back(rv_fetch_pkg::RESET_PC);
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;

    wait_token(32'h220);                                   // Plain sequential fetch
    rand_on = 1'b1;
    wait_token(32'h280);
    rand_on = 1'b0;
    wait_r_beat();
    hold_stall = 1'b1;                                     // Next token lands and is held
    send_redirect(1'b0, '0, 1'b1, 32'h100, 1'b1);          // Branch with flush
    hold_stall = 1'b0;
    rand_on    = 1'b1;
    wait_token(32'h110);
    send_redirect(1'b1, 32'h140, 1'b1, 32'h180, 1'b0);
    wait_token(32'h150);
    rand_on = 1'b0;

    train_btb(32'h168, 32'h1A0, 1'b1);
    wait_token(32'h1A4);
    train_btb(32'h168, 32'h000, 1'b0);
    send_redirect(1'b0, '0, 1'b1, 32'h160, 1'b0);
    wait_token(32'h170);

    send_redirect(1'b0, '0, 1'b1, 32'h302, 1'b0);
    wait_fault(rv_fetch_pkg::FAULT_MISALIGNED, 32'h302);
    check_no_new_read(20);
    send_redirect(1'b1, 32'h200, 1'b0, '0, 1'b0);
    wait_token(32'h204);

    send_redirect(1'b0, '0, 1'b1, ERR_ADDR, 1'b0);
    wait_fault(rv_fetch_pkg::FAULT_ACCESS, ERR_ADDR);
    send_redirect(1'b1, 32'h200, 1'b0, '0, 1'b0);
    wait_token(32'h204);
    send_redirect(1'b0, '0, 1'b1, HANG_ADDR, 1'b0);
    wait_fault(rv_fetch_pkg::FAULT_ACCESS, HANG_ADDR);
    send_redirect(1'b1, 32'h210, 1'b0, '0, 1'b0);
    wait_token(32'h218);

    if (fault_count != 3) begin
      $display("Saw %0d faults where 3 were expected", fault_count);
      other_errs++;
    end
    finish_run();
  end

endmodule

`default_nettype wire
